// ==== sim/simt_alu_cluster_chk.sv ====
// lane assertions, bound into every exec_lane
// load collisions, valid pipeline, x0 read back
`timescale 1ns/1ps

module simt_alu_cluster_chk import simt_alu_pkg::*; (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  iss_valid,
	input logic                  iss_wen,
	input logic                  ld_en,
	input logic                  lane_valid,
	input logic [REG_ADDR_W-1:0] iss_rd,
	input logic [REG_ADDR_W-1:0] iss_rs1,
	input logic [XLEN-1:0]       rs1_data
);

	// external load on the same edge as a writeback
	no_load_on_writeback: assert property (@(posedge clk) disable iff (!rst_n)
		!(iss_wen && ld_en))
		else $error("external load collides with writeback in the lane register file");

	// lane result only follows an issued word
	valid_follows_issue: assert property (@(posedge clk) disable iff (!rst_n)
		!iss_valid |=> !lane_valid)
		else $error("lane_valid rose without iss_valid in the cycle before");

	// x0 still reads zero right after an x0 destination
	x0_stays_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(iss_valid && iss_rd == '0) ##1 (iss_rs1 == '0) |-> (rs1_data == '0))
		else $error("x0 read back nonzero after a write to x0");

endmodule

bind exec_lane simt_alu_cluster_chk u_simt_alu_cluster_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.iss_valid  (iss_valid),
	.iss_wen    (iss_wen),
	.ld_en      (ld_en),
	.lane_valid (lane_valid),
	.iss_rd     (iss_rd),
	.iss_rs1    (iss_rs1),
	.rs1_data   (rs1_data)
);

// ==== sim/simt_alu_cluster_tb.sv ====
// testbench for the lane-parallel execute cluster
// lfsr register fill, per-lane reference model, directed tests
`timescale 1ns/1ps

module simt_alu_cluster_tb import simt_alu_pkg::*; ();

	localparam int NUM_LANES = 4;
	// cycles allowed for any wait loop
	localparam int TIMEOUT   = 20;

	logic                      clk;
	logic                      rst_n;
	logic                      instr_valid;
	logic [XLEN-1:0]           instr;
	logic                      load_valid;
	logic [LANE_W-1:0]         load_lane;
	logic [REG_ADDR_W-1:0]     load_addr;
	logic [XLEN-1:0]           load_data;
	logic                      result_valid;
	logic [NUM_LANES*XLEN-1:0] result_data;
	logic [NUM_LANES-1:0]      zero_mask;
	logic                      illegal;

	// shadow copy of every lane register file
	logic [XLEN-1:0] shadow [NUM_LANES][32];
	logic [15:0]     lfsr_state = 16'd90;

	simt_alu_cluster #(
		.NUM_LANES (NUM_LANES)
	) u_simt_alu_cluster (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.load_valid   (load_valid),
		.load_lane    (load_lane),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.result_valid (result_valid),
		.result_data  (result_data),
		.zero_mask    (zero_mask),
		.illegal      (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_failed(input string line);
		$display("%s", line);
		$display("Verification failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_equal(input logic [NUM_LANES*XLEN-1:0] got,
			input logic [NUM_LANES*XLEN-1:0] exp, input string what);
		if (got !== exp) begin
			stop_failed($sformatf("mismatch at time %0t: %s, got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	// 16-bit fibonacci lfsr, taps 16 14 13 11
	function automatic logic lfsr_bit();
		logic fb;
		fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [XLEN-1:0] rand_word();
		logic [XLEN-1:0] w;
		w = '0;
		for (int i = 0; i < XLEN; i++) begin
			w = {w[XLEN-2:0], lfsr_bit()};
		end
		return w;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	// rv32 semantics per lane, top bit is the zero flag of the raw result
	function automatic logic [XLEN:0] expect_lane(input logic [31:0] word,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] rb);
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] diff;
		logic [XLEN-1:0] raw;
		logic [XLEN-1:0] res;
		b    = (word[6:0] == OPC_OP) ? rb : {{20{word[31]}}, word[31:20]};
		diff = a - b;
		case (word[14:12])
			3'd0:    raw = (word[30] && word[6:0] == OPC_OP) ? diff : a + b;
			3'd1:    raw = a << b[4:0];
			3'd2:    raw = diff;
			3'd3:    raw = diff;
			3'd4:    raw = a ^ b;
			3'd5: begin
				if (word[30])
					raw = $signed(a) >>> b[4:0];
				else
					raw = a >> b[4:0];
			end
			3'd6:    raw = a | b;
			default: raw = a & b;
		endcase
		res = raw;
		// slt is the sign of the wrapped difference, sltu is the borrow
		if (word[14:12] == 3'd2)
			res = {31'b0, diff[31]};
		if (word[14:12] == 3'd3)
			res = {31'b0, a < b};
		if (word[6:0] == OPC_LUI) begin
			raw = {word[31:12], 12'b0};
			res = raw;
		end
		return {raw == '0, res};
	endfunction

	// expected outputs for all lanes, then shadow writeback
	task automatic model_instr(input logic [31:0] word,
			output logic [NUM_LANES*XLEN-1:0] exp_data,
			output logic [NUM_LANES-1:0] exp_zero, output logic legal);
		logic [XLEN:0] r;
		logic [4:0]    rd;
		legal = word[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LUI};
		rd    = word[11:7];
		for (int l = 0; l < NUM_LANES; l++) begin
			r = expect_lane(word, shadow[l][word[19:15]], shadow[l][word[24:20]]);
			exp_data[l*XLEN +: XLEN] = r[XLEN-1:0];
			exp_zero[l]              = r[XLEN];
			if (legal && rd != '0)
				shadow[l][rd] = r[XLEN-1:0];
		end
	endtask

	task automatic load_reg(input int lane, input logic [4:0] addr,
			input logic [XLEN-1:0] data);
		@(posedge clk);
		load_valid <= 1'b1;
		load_lane  <= LANE_W'(lane);
		load_addr  <= addr;
		load_data  <= data;
		if (addr != '0)
			shadow[lane][addr] = data;
	endtask

	task automatic fill_regs();
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int r = 1; r < 32; r++) begin
				load_reg(l, 5'(r), rand_word());
			end
		end
		// lane 1 x3 equals x1, so sub gives zero there
		load_reg(1, 5'd3, shadow[1][1]);
		// lane 3 x1 - x3 overflows
		load_reg(3, 5'd1, 32'h8000_0000);
		load_reg(3, 5'd3, 32'h0000_0001);
		@(posedge clk);
		load_valid <= 1'b0;
	endtask

	// edges from the last sampled issue until a result or illegal strobe
	task automatic wait_output(output int edges);
		edges = 0;
		do begin
			@(posedge clk);
			#1;
			edges++;
		end while (!result_valid && !illegal && edges < TIMEOUT);
		if (!result_valid && !illegal) begin
			stop_failed($sformatf("timeout: no result or illegal strobe within %0d cycles",
				TIMEOUT));
		end
	endtask

	task automatic check_outputs(input logic legal, input logic [NUM_LANES*XLEN-1:0] exp_data,
			input logic [NUM_LANES-1:0] exp_zero, input string what);
		check_equal(result_valid, legal, {what, " result_valid"});
		check_equal(illegal, !legal, {what, " illegal"});
		if (legal) begin
			check_equal(result_data, exp_data, {what, " result_data"});
			check_equal(zero_mask, exp_zero, {what, " zero_mask"});
		end
	endtask

	task automatic run_instr(input logic [31:0] word, input string what);
		logic [NUM_LANES*XLEN-1:0] exp_data;
		logic [NUM_LANES-1:0]      exp_zero;
		logic                      legal;
		int                        edges;
		model_instr(word, exp_data, exp_zero, legal);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= word;
		@(posedge clk);
		instr_valid <= 1'b0;
		wait_output(edges);
		check_equal(edges, 2, {what, " latency"});
		check_outputs(legal, exp_data, exp_zero, what);
	endtask

	// two words on consecutive edges, second may depend on the first
	task automatic run_pair(input logic [31:0] first, input logic [31:0] second,
			input string what);
		logic [NUM_LANES*XLEN-1:0] data_a;
		logic [NUM_LANES*XLEN-1:0] data_b;
		logic [NUM_LANES-1:0]      zero_a;
		logic [NUM_LANES-1:0]      zero_b;
		logic                      legal_a;
		logic                      legal_b;
		int                        edges;
		model_instr(first, data_a, zero_a, legal_a);
		model_instr(second, data_b, zero_b, legal_b);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= first;
		@(posedge clk);
		instr       <= second;
		@(posedge clk);
		instr_valid <= 1'b0;
		wait_output(edges);
		// first result lands one edge after the second issue
		check_equal(edges, 1, {what, " first latency"});
		check_outputs(legal_a, data_a, zero_a, {what, " first"});
		@(posedge clk);
		#1;
		check_outputs(legal_b, data_b, zero_b, {what, " second"});
	endtask

	task automatic reset_behavior();
		repeat (3) begin
			@(posedge clk);
			#1;
			check_equal(result_valid, 1'b0, "result_valid after reset");
			check_equal(illegal, 1'b0, "illegal after reset");
		end
		run_instr(enc_i(12'h000, 5'd0, F3_ADD_SUB, 5'd1), "addi x1, x0, 0");
		check_equal(result_data, '0, "addi from x0 data");
		check_equal(zero_mask, {NUM_LANES{1'b1}}, "addi from x0 mask");
	endtask

	task automatic r_type_ops();
		for (int f = 0; f < 8; f++) begin
			run_instr(enc_r(F7_BASE, 5'd3, 5'd1, 3'(f), 5'(10 + f)),
				$sformatf("r-type funct3 %0d", f));
		end
		run_instr(enc_r(F7_ALT, 5'd3, 5'd1, F3_ADD_SUB, 5'd18), "sub");
		run_instr(enc_r(F7_ALT, 5'd2, 5'd4, F3_SR, 5'd19), "sra");
		run_instr(enc_r(F7_BASE, 5'd1, 5'd3, F3_SLT, 5'd9), "slt reversed");
	endtask

	task automatic i_type_ops();
		run_instr(enc_i(12'hffb, 5'd1, F3_ADD_SUB, 5'd11), "addi negative");
		run_instr(enc_i(12'hfff, 5'd2, F3_SLT, 5'd12), "slti -1");
		run_instr(enc_i(12'hfff, 5'd2, F3_SLTU, 5'd13), "sltiu -1");
		run_instr(enc_i(12'h800, 5'd0, F3_SLT, 5'd26), "slti x0 -2048");
		run_instr(enc_i(12'h800, 5'd4, F3_XOR, 5'd14), "xori");
		run_instr(enc_i(12'hf0f, 5'd5, F3_OR, 5'd15), "ori");
		run_instr(enc_i(12'h8f0, 5'd6, F3_AND, 5'd16), "andi");
		run_instr(enc_i(12'h01f, 5'd7, F3_SLL, 5'd17), "slli 31");
		run_instr(enc_i(12'h007, 5'd8, F3_SR, 5'd18), "srli 7");
		run_instr(enc_i(12'h40d, 5'd9, F3_SR, 5'd19), "srai 13");
		run_instr(enc_i(12'h400, 5'd1, F3_SR, 5'd27), "srai 0");
	endtask

	task automatic lui_and_dependency();
		run_instr({20'habcde, 5'd20, OPC_LUI}, "lui");
		run_pair({20'h12345, 5'd21, OPC_LUI}, enc_i(12'h678, 5'd21, F3_ADD_SUB, 5'd21),
			"lui then addi");
		run_pair(enc_i(12'h001, 5'd21, F3_ADD_SUB, 5'd22),
			enc_r(F7_BASE, 5'd1, 5'd22, F3_XOR, 5'd23), "addi then xor");
		// x0 write followed at once by an x0 read
		run_pair(enc_i(12'h005, 5'd1, F3_ADD_SUB, 5'd0),
			enc_r(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd24), "x0 write then read");
	endtask

	task automatic illegal_word();
		// lw x5 and an all ones opcode, both with rd x5
		run_instr({12'h004, 5'd1, 3'b010, 5'd5, 7'b0000011}, "load opcode");
		run_instr(enc_i(12'h000, 5'd5, F3_ADD_SUB, 5'd25), "x5 after illegal");
		run_instr({25'h0000_0a5, 7'b1111111}, "all ones opcode");
		run_instr(enc_r(F7_BASE, 5'd0, 5'd5, F3_OR, 5'd26), "x5 after second illegal");
	endtask

	initial begin
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		load_valid  = 1'b0;
		load_lane   = '0;
		load_addr   = '0;
		load_data   = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int r = 0; r < 32; r++) begin
				shadow[l][r] = '0;
			end
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		reset_behavior();
		fill_regs();
		r_type_ops();
		i_type_ops();
		lui_and_dependency();
		illegal_word();
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== simt_alu_cluster.f ====
source/simt_alu_pkg.sv
source/rv_issue_decoder.sv
source/lane_regfile.sv
source/lane_alu.sv
source/exec_lane.sv
source/lane_collector.sv
source/simt_alu_cluster.sv
sim/simt_alu_cluster_chk.sv
sim/simt_alu_cluster_tb.sv

// ==== source/exec_lane.sv ====
// one execute lane with private register file and alu
// result register doubles as the writeback stage
`timescale 1ns/1ps

module exec_lane import simt_alu_pkg::*; #(
	parameter int unsigned LANE_ID = 0
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  iss_valid,
	input  logic [3:0]            iss_op,
	input  logic [REG_ADDR_W-1:0] iss_rs1,
	input  logic [REG_ADDR_W-1:0] iss_rs2,
	input  logic [REG_ADDR_W-1:0] iss_rd,
	input  logic                  iss_use_imm,
	input  logic [XLEN-1:0]       iss_imm,
	input  logic                  iss_wen,
	input  logic                  load_valid,
	input  logic [LANE_W-1:0]     load_lane,
	input  logic [REG_ADDR_W-1:0] load_addr,
	input  logic [XLEN-1:0]       load_data,
	output logic                  lane_valid,
	output logic [XLEN-1:0]       lane_result,
	output logic                  lane_zero
);

	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] alu_result;
	logic            alu_zero;
	logic            ld_en;

	// load strobe addressed to this lane
	assign ld_en = load_valid && (load_lane == LANE_W'(LANE_ID));
	assign src2  = iss_use_imm ? iss_imm : rs2_data;

	// writeback uses the alu output so it lands with the result register
	lane_regfile u_lane_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_addr (iss_rs1),
		.rs2_addr (iss_rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_en    (iss_wen),
		.wb_addr  (iss_rd),
		.wb_data  (alu_result),
		.ld_en    (ld_en),
		.ld_addr  (load_addr),
		.ld_data  (load_data)
	);

	lane_alu u_lane_alu (
		.src1        (rs1_data),
		.src2        (src2),
		.alu_control (iss_op),
		.result      (alu_result),
		.zero        (alu_zero)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lane_valid <= 1'b0;
		end else begin
			lane_valid <= iss_valid;
		end
	end

	// result and flag held until the next issue
	always_ff @(posedge clk) begin
		if (iss_valid) begin
			lane_result <= alu_result;
			lane_zero   <= alu_zero;
		end
	end

endmodule

// ==== source/lane_alu.sv ====
// combinational lane alu, fourteen operation codes
// zero flag taken from the raw result before slt mapping
`timescale 1ns/1ps

module lane_alu import simt_alu_pkg::*; (
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [3:0]      alu_control,
	output logic [XLEN-1:0] result,
	output logic            zero
);

	// raw operation result
	logic [XLEN-1:0] raw;
	// src1 + ~src2 + 1 with carry out on top
	logic [XLEN:0]   diff_ext;
	logic            carry;

	assign diff_ext = {1'b0, src1} + {1'b0, ~src2} + (XLEN+1)'(1);
	assign carry    = diff_ext[XLEN];

	always_comb begin
		case (alu_control)
			ALU_ADD:   raw = src1 + src2;
			ALU_SUB:   raw = diff_ext[XLEN-1:0];
			// full width shift amount, big values flush to zero
			ALU_SLL:   raw = src1 << src2;
			// slt and sltu keep the difference as raw result
			ALU_SLT:   raw = diff_ext[XLEN-1:0];
			ALU_SLTU:  raw = diff_ext[XLEN-1:0];
			ALU_XOR:   raw = src1 ^ src2;
			ALU_SRL:   raw = src1 >> src2;
			ALU_SRA:   raw = $signed(src1) >>> src2;
			ALU_OR:    raw = src1 | src2;
			ALU_AND:   raw = src1 & src2;
			// pass src2 through, used by lui
			ALU_PASSB: raw = src2;
			ALU_SRL5:  raw = src1 >> src2[4:0];
			ALU_SLL5:  raw = src1 << src2[4:0];
			ALU_SRA5:  raw = $signed(src1) >>> src2[4:0];
			// undefined codes
			default:   raw = '0;
		endcase
	end

	always_comb begin
		case (alu_control)
			// sign of the difference, wraps on signed overflow
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, raw[XLEN-1]};
			// no carry out means src1 below src2
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, ~carry};
			default:  result = raw;
		endcase
	end

	assign zero = (raw == '0);

endmodule

// ==== source/lane_collector.sv ====
// gathers lane results into one output word and zero mask
// issues result_valid or illegal for one cycle
`timescale 1ns/1ps

module lane_collector import simt_alu_pkg::*; #(
	parameter int NUM_LANES = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      lane_valid,
	input  logic [NUM_LANES*XLEN-1:0] lane_results,
	input  logic [NUM_LANES-1:0]      lane_zeros,
	input  logic                      lane_illegal,
	output logic                      result_valid,
	output logic [NUM_LANES*XLEN-1:0] result_data,
	output logic [NUM_LANES-1:0]      zero_mask,
	output logic                      illegal
);

	// illegal replaces the result strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			illegal      <= 1'b0;
		end else begin
			result_valid <= lane_valid && !lane_illegal;
			illegal      <= lane_valid && lane_illegal;
		end
	end

	// lane 0 in the low bits, as flattened by the top level
	always_ff @(posedge clk) begin
		if (lane_valid) begin
			result_data <= lane_results;
			zero_mask   <= lane_zeros;
		end
	end

endmodule

// ==== source/lane_regfile.sv ====
// per-lane 32x32 register file, two async reads
// writeback port has priority over the external load port
`timescale 1ns/1ps

module lane_regfile import simt_alu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] rs1_addr,
	input  logic [REG_ADDR_W-1:0] rs2_addr,
	output logic [XLEN-1:0]       rs1_data,
	output logic [XLEN-1:0]       rs2_data,
	input  logic                  wb_en,
	input  logic [REG_ADDR_W-1:0] wb_addr,
	input  logic [XLEN-1:0]       wb_data,
	input  logic                  ld_en,
	input  logic [REG_ADDR_W-1:0] ld_addr,
	input  logic [XLEN-1:0]       ld_data
);

	logic [XLEN-1:0] regs [2**REG_ADDR_W];

	// all registers read zero out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			if (wb_addr != '0) begin
				regs[wb_addr] <= wb_data;
			end
		end else if (ld_en && ld_addr != '0) begin
			// load only when no writeback this edge
			regs[ld_addr] <= ld_data;
		end
	end

	// x0 hardwired to zero
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== source/rv_issue_decoder.sv ====
// instruction register and decoder
// broadcasts operation, operands and immediate to every lane
`timescale 1ns/1ps

module rv_issue_decoder import simt_alu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  instr_valid,
	input  logic [XLEN-1:0]       instr,
	output logic                  iss_valid,
	output logic [3:0]            iss_op,
	output logic [REG_ADDR_W-1:0] iss_rs1,
	output logic [REG_ADDR_W-1:0] iss_rs2,
	output logic [REG_ADDR_W-1:0] iss_rd,
	output logic                  iss_use_imm,
	output logic [XLEN-1:0]       iss_imm,
	output logic                  iss_wen,
	output logic                  iss_illegal
);

	rv_instr_u       instr_u;
	logic [3:0]      dec_op;
	logic            dec_use_imm;
	logic [XLEN-1:0] dec_imm;
	logic            dec_bad;
	logic            f7_base;
	logic            f7_alt;
	// first illegal stage, second one is iss_illegal
	logic            illegal_q;

	// funct3 to alu code, alt picks sub or sra
	function automatic logic [3:0] alu_from_f3(input logic [2:0] f3, input logic alt);
		logic [3:0] op;
		case (f3)
			F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
			F3_SLL:     op = ALU_SLL5;
			F3_SLT:     op = ALU_SLT;
			F3_SLTU:    op = ALU_SLTU;
			F3_XOR:     op = ALU_XOR;
			F3_SR:      op = alt ? ALU_SRA5 : ALU_SRL5;
			F3_OR:      op = ALU_OR;
			default:    op = ALU_AND;
		endcase
		return op;
	endfunction

	assign instr_u = instr;
	assign f7_base = (instr_u.r.funct7 == F7_BASE);
	assign f7_alt  = (instr_u.r.funct7 == F7_ALT);

	always_comb begin
		dec_op      = ALU_ADD;
		dec_use_imm = 1'b0;
		dec_imm     = '0;
		dec_bad     = 1'b0;
		case (instr_u.r.opcode)
			OPC_OP: begin
				dec_op  = alu_from_f3(instr_u.r.funct3, f7_alt);
				// alt funct7 only legal on add/sub and the right shifts
				dec_bad = !(f7_base || f7_alt) ||
				          (f7_alt && instr_u.r.funct3 != F3_ADD_SUB &&
				           instr_u.r.funct3 != F3_SR);
			end
			OPC_OP_IMM: begin
				// addi has no funct7, its top bits are immediate
				dec_op      = alu_from_f3(instr_u.i.funct3,
				                          f7_alt && instr_u.i.funct3 == F3_SR);
				dec_use_imm = 1'b1;
				dec_imm     = {{(XLEN-12){instr_u.i.imm12[11]}}, instr_u.i.imm12};
				dec_bad     = (instr_u.i.funct3 == F3_SLL && !f7_base) ||
				              (instr_u.i.funct3 == F3_SR && !(f7_base || f7_alt));
			end
			OPC_LUI: begin
				dec_op      = ALU_PASSB;
				dec_use_imm = 1'b1;
				dec_imm     = {instr_u.u.imm20, 12'b0};
			end
			default: dec_bad = 1'b1;
		endcase
	end

	// control flops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			iss_valid   <= 1'b0;
			iss_wen     <= 1'b0;
			illegal_q   <= 1'b0;
			iss_illegal <= 1'b0;
		end else begin
			iss_valid   <= instr_valid;
			// no writeback for illegal words or rd x0
			iss_wen     <= instr_valid && !dec_bad && (instr_u.r.rd != '0);
			illegal_q   <= instr_valid && dec_bad;
			// delayed to line up with lane_valid
			iss_illegal <= illegal_q;
		end
	end

	// decoded payload, only loaded on a new word
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			iss_op      <= dec_op;
			iss_rs1     <= instr_u.r.rs1;
			iss_rs2     <= instr_u.r.rs2;
			iss_rd      <= instr_u.r.rd;
			iss_use_imm <= dec_use_imm;
			iss_imm     <= dec_imm;
		end
	end

endmodule

// ==== source/simt_alu_cluster.sv ====
// top level of the execute cluster
// decoder, generate loop of lanes, result collector
`timescale 1ns/1ps

module simt_alu_cluster import simt_alu_pkg::*; #(
	parameter int NUM_LANES = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      instr_valid,
	input  logic [XLEN-1:0]           instr,
	input  logic                      load_valid,
	input  logic [LANE_W-1:0]         load_lane,
	input  logic [REG_ADDR_W-1:0]     load_addr,
	input  logic [XLEN-1:0]           load_data,
	output logic                      result_valid,
	output logic [NUM_LANES*XLEN-1:0] result_data,
	output logic [NUM_LANES-1:0]      zero_mask,
	output logic                      illegal
);

	// issue broadcast
	logic                  iss_valid;
	logic [3:0]            iss_op;
	logic [REG_ADDR_W-1:0] iss_rs1;
	logic [REG_ADDR_W-1:0] iss_rs2;
	logic [REG_ADDR_W-1:0] iss_rd;
	logic                  iss_use_imm;
	logic [XLEN-1:0]       iss_imm;
	logic                  iss_wen;
	logic                  iss_illegal;

	// per lane outputs, lanes run in lockstep
	logic [NUM_LANES-1:0]      lane_valid;
	logic [NUM_LANES*XLEN-1:0] lane_results;
	logic [NUM_LANES-1:0]      lane_zeros;

	rv_issue_decoder u_rv_issue_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.iss_valid   (iss_valid),
		.iss_op      (iss_op),
		.iss_rs1     (iss_rs1),
		.iss_rs2     (iss_rs2),
		.iss_rd      (iss_rd),
		.iss_use_imm (iss_use_imm),
		.iss_imm     (iss_imm),
		.iss_wen     (iss_wen),
		.iss_illegal (iss_illegal)
	);

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		exec_lane #(
			.LANE_ID (g)
		) u_exec_lane (
			.clk         (clk),
			.rst_n       (rst_n),
			.iss_valid   (iss_valid),
			.iss_op      (iss_op),
			.iss_rs1     (iss_rs1),
			.iss_rs2     (iss_rs2),
			.iss_rd      (iss_rd),
			.iss_use_imm (iss_use_imm),
			.iss_imm     (iss_imm),
			.iss_wen     (iss_wen),
			.load_valid  (load_valid),
			.load_lane   (load_lane),
			.load_addr   (load_addr),
			.load_data   (load_data),
			.lane_valid  (lane_valid[g]),
			.lane_result (lane_results[g*XLEN +: XLEN]),
			.lane_zero   (lane_zeros[g])
		);
	end

	// lane 0 valid stands for all lanes
	lane_collector #(
		.NUM_LANES (NUM_LANES)
	) u_lane_collector (
		.clk          (clk),
		.rst_n        (rst_n),
		.lane_valid   (lane_valid[0]),
		.lane_results (lane_results),
		.lane_zeros   (lane_zeros),
		.lane_illegal (iss_illegal),
		.result_valid (result_valid),
		.result_data  (result_data),
		.zero_mask    (zero_mask),
		.illegal      (illegal)
	);

endmodule

// ==== source/simt_alu_pkg.sv ====
// shared constants for the lane-parallel rv32 execute cluster
// alu operation codes, opcode and funct fields, instruction union
package simt_alu_pkg;

	// data word and register index widths, rv32 only
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	// width of the lane select on the external load port
	localparam int LANE_W     = 8;

	// alu operation codes, same encoding as the scalar alu
	localparam logic [3:0] ALU_ADD   = 4'b0000;
	localparam logic [3:0] ALU_SUB   = 4'b0001;
	localparam logic [3:0] ALU_SLL   = 4'b0010;
	localparam logic [3:0] ALU_SLT   = 4'b0011;
	localparam logic [3:0] ALU_SLTU  = 4'b0100;
	localparam logic [3:0] ALU_XOR   = 4'b0101;
	localparam logic [3:0] ALU_SRL   = 4'b0110;
	localparam logic [3:0] ALU_SRA   = 4'b0111;
	localparam logic [3:0] ALU_OR    = 4'b1000;
	localparam logic [3:0] ALU_AND   = 4'b1001;
	localparam logic [3:0] ALU_PASSB = 4'b1010;
	// masked shifts, only the low 5 bits of src2 count
	localparam logic [3:0] ALU_SRL5  = 4'b1011;
	localparam logic [3:0] ALU_SLL5  = 4'b1100;
	localparam logic [3:0] ALU_SRA5  = 4'b1101;

	// major opcodes accepted by the decoder
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	// funct3 per operation group
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7 values, alt selects sub and sra
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// one instruction word seen as r, i or u format
	typedef union packed {
		struct packed {
			logic [6:0]            funct7;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0]            funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} r;
		struct packed {
			logic [11:0]           imm12;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0]            funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} i;
		struct packed {
			logic [19:0]           imm20;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} u;
	} rv_instr_u;

endpackage
